// ==== hdl/dma_pkg.sv ====
// Shared definitions for the four-channel DMA engine
// Widths and vector types, register offsets, control field positions,
// transfer size codes and the per-channel state enum
package dma_pkg;

    localparam int NUM_CHAN = 4;
    localparam int NUM_REQ  = 16;    // Request lines
    localparam int ADDR_W   = 22;
    localparam int CTRL_W   = 12;
    localparam int DATA_W   = 32;
    localparam int REQ_SEL_W = 4;

    typedef logic [ADDR_W-1:0] addr_t;    // Byte address or byte count
    typedef logic [CTRL_W-1:0] ctrl_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [3:0]        mask_t;    // One bit per byte lane
    typedef logic [1:0]        chan_t;
    typedef logic [5:0]        reg_off_t;

    // Control register fields
    localparam int CTRL_SRC_REQ_LSB = 0;
    localparam int CTRL_DST_REQ_LSB = 4;
    localparam int CTRL_SRC_INC     = 8;
    localparam int CTRL_DST_INC     = 9;
    localparam int CTRL_SIZE_LSB    = 10;

    localparam logic [1:0] SIZE_8  = 2'd0;
    localparam logic [1:0] SIZE_16 = 2'd1;
    localparam logic [1:0] SIZE_32 = 2'd2;

    // Word offsets inside one channel block, block n starts at 16*n
    localparam reg_off_t REG_SRC  = 6'd0;
    localparam reg_off_t REG_DST  = 6'd4;
    localparam reg_off_t REG_CTRL = 6'd8;
    localparam reg_off_t REG_CNT  = 6'd12;

    typedef enum logic [2:0] {
        ST_SRC_RDY,
        ST_RD_REQ,
        ST_RD_RSP,
        ST_DST_RDY,
        ST_WR_REQ,
        ST_WR_RSP,
        ST_STATUS
    } chan_state_e;

endpackage

// ==== hdl/dma_reg_file.sv ====
// Channel register storage for the DMA engine
// Source, destination, control and count per channel, host writes,
// transfer step updates and the read-back mux
`timescale 1ns/1ps

module dma_reg_file import dma_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                reg_cs,
    input  logic                reg_wr,
    input  reg_off_t            reg_addr,
    input  word_t               reg_wdata,
    output word_t               reg_rdata,
    input  chan_t               chan_num,
    input  logic [NUM_CHAN-1:0] update,
    input  addr_t               next_src,
    input  addr_t               next_dst,
    input  addr_t               next_cnt,
    output addr_t               sel_src,
    output addr_t               sel_dst,
    output addr_t               sel_cnt,
    output ctrl_t               sel_ctrl
);

    addr_t src_r  [NUM_CHAN];
    addr_t dst_r  [NUM_CHAN];
    ctrl_t ctrl_r [NUM_CHAN];
    addr_t cnt_r  [NUM_CHAN];

    chan_t    reg_chan;
    reg_off_t word_off;
    logic     reg_write;

    assign reg_chan  = reg_addr[5:4];
    assign word_off  = {2'b00, reg_addr[3:2], 2'b00};    // Byte lanes ignored
    assign reg_write = reg_cs && reg_wr;

    // Host writes win over a step update in the same cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                src_r[i]  <= '0;
                dst_r[i]  <= '0;
                ctrl_r[i] <= '0;
                cnt_r[i]  <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                if (reg_write && reg_chan == i && word_off == REG_SRC)
                    src_r[i] <= reg_wdata[ADDR_W-1:0];
                else if (update[i] && ctrl_r[i][CTRL_SRC_INC])
                    src_r[i] <= next_src;

                if (reg_write && reg_chan == i && word_off == REG_DST)
                    dst_r[i] <= reg_wdata[ADDR_W-1:0];
                else if (update[i] && ctrl_r[i][CTRL_DST_INC])
                    dst_r[i] <= next_dst;

                if (reg_write && reg_chan == i && word_off == REG_CTRL)
                    ctrl_r[i] <= reg_wdata[CTRL_W-1:0];

                if (reg_write && reg_chan == i && word_off == REG_CNT)
                    cnt_r[i] <= reg_wdata[ADDR_W-1:0];
                else if (update[i])
                    cnt_r[i] <= next_cnt;
            end
        end
    end

    always_comb
    begin
        reg_rdata = '0;
        case (word_off)
            REG_SRC:  reg_rdata = word_t'(src_r[reg_chan]);
            REG_DST:  reg_rdata = word_t'(dst_r[reg_chan]);
            REG_CTRL: reg_rdata = word_t'(ctrl_r[reg_chan]);
            REG_CNT:  reg_rdata = word_t'(cnt_r[reg_chan]);
            default:  reg_rdata = '0;
        endcase
    end

    assign sel_src  = src_r[chan_num];
    assign sel_dst  = dst_r[chan_num];
    assign sel_ctrl = ctrl_r[chan_num];
    assign sel_cnt  = cnt_r[chan_num];

    // Only the slot owner may finish a step
    a_update_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(update));

endmodule

// ==== hdl/dma_step_calc.sv ====
// Transfer step arithmetic for the selected channel
// Byte-lane masks, next source and destination addresses, next count
`timescale 1ns/1ps

module dma_step_calc import dma_pkg::*;
(
    input  addr_t sel_src,
    input  addr_t sel_dst,
    input  addr_t sel_cnt,
    input  ctrl_t sel_ctrl,
    output addr_t next_src,
    output addr_t next_dst,
    output addr_t next_cnt,
    output mask_t src_mask,
    output mask_t dst_mask
);

    logic [1:0] size;
    logic       word_size;
    logic       half_size;

    function automatic addr_t step_addr(addr_t a, logic word, logic half);
        if (word)
            return {a[ADDR_W-1:2] + 1'b1, 2'b00};
        else if (half)
            return {a[ADDR_W-1:1] + 1'b1, 1'b0};
        return a + 1'b1;
    endfunction

    function automatic mask_t lane_mask(addr_t a, logic word, logic half);
        if (word)
            return 4'b1111;
        else if (half)
            return a[1] ? 4'b1100 : 4'b0011;
        return mask_t'(1) << a[1:0];
    endfunction

    assign size      = sel_ctrl[CTRL_SIZE_LSB +: 2];
    assign word_size = (size >= SIZE_32);    // Reserved code acts as 32-bit
    assign half_size = (size == SIZE_16);

    assign next_src = step_addr(sel_src, word_size, half_size);
    assign next_dst = step_addr(sel_dst, word_size, half_size);
    assign src_mask = lane_mask(sel_src, word_size, half_size);
    assign dst_mask = lane_mask(sel_dst, word_size, half_size);

    // Count stays aligned to the size
    assign next_cnt = word_size ? {sel_cnt[ADDR_W-1:2] - 1'b1, 2'b00} :
                      half_size ? {sel_cnt[ADDR_W-1:1] - 1'b1, 1'b0} :
                      sel_cnt - 1'b1;

endmodule

// ==== hdl/dma_resp_tracker.sv ====
// Outstanding read and write tracking per channel
// Captured read data, replicated across all byte lanes
`timescale 1ns/1ps

module dma_resp_tracker import dma_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  mst_cs,
    input  logic  mst_wr,
    input  logic  mst_busy,
    input  chan_t mst_seq,
    input  logic  rdone,
    input  logic  wdone,
    input  chan_t rsp_seq,
    input  mask_t rsp_mask,
    input  word_t rsp_data,
    input  chan_t chan_num,
    output logic  sel_rpend,
    output logic  sel_wpend,
    output word_t sel_rdata
);

    logic [NUM_CHAN-1:0] rpend;
    logic [NUM_CHAN-1:0] wpend;
    logic [NUM_CHAN-1:0] set_rpend;
    logic [NUM_CHAN-1:0] set_wpend;
    logic [NUM_CHAN-1:0] clr_rpend;
    logic [NUM_CHAN-1:0] clr_wpend;
    word_t               rdata_r [NUM_CHAN];
    word_t               rsp_rep;
    logic                accept;

    assign accept = mst_cs && !mst_busy;

    assign set_rpend = (accept && !mst_wr) ? NUM_CHAN'(1) << mst_seq : '0;
    assign set_wpend = (accept && mst_wr) ? NUM_CHAN'(1) << mst_seq : '0;
    assign clr_rpend = rdone ? NUM_CHAN'(1) << rsp_seq : '0;
    assign clr_wpend = wdone ? NUM_CHAN'(1) << rsp_seq : '0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rpend <= '0;
            wpend <= '0;
        end
        else
        begin
            rpend <= (rpend | set_rpend) & ~clr_rpend;
            wpend <= (wpend | set_wpend) & ~clr_wpend;
        end
    end

    // Spread the active lanes so any destination lane can pick them up
    always_comb
    begin
        if (rsp_mask == 4'b1111)
            rsp_rep = rsp_data;
        else if (rsp_mask[3:2] == 2'b11)
            rsp_rep = {2{rsp_data[31:16]}};
        else if (rsp_mask[1:0] == 2'b11)
            rsp_rep = {2{rsp_data[15:0]}};
        else if (rsp_mask[3])
            rsp_rep = {4{rsp_data[31:24]}};
        else if (rsp_mask[2])
            rsp_rep = {4{rsp_data[23:16]}};
        else if (rsp_mask[1])
            rsp_rep = {4{rsp_data[15:8]}};
        else
            rsp_rep = {4{rsp_data[7:0]}};
    end

    always_ff @(posedge clk)
    begin
        if (rdone)
            rdata_r[rsp_seq] <= rsp_rep;
    end

    assign sel_rpend = rpend[chan_num];
    assign sel_wpend = wpend[chan_num];
    assign sel_rdata = rdata_r[chan_num];

    // A response must follow an accepted request of the same channel
    a_rdone_pending: assert property (@(posedge clk) disable iff (rst) rdone |-> rpend[rsp_seq]);
    a_wdone_pending: assert property (@(posedge clk) disable iff (rst) wdone |-> wpend[rsp_seq]);

endmodule

// ==== hdl/dma_chan_sched.sv ====
// Slot scheduler and per-channel transfer FSM
// Request line sampling, slot rotation, channel states and the
// master request outputs for the channel owning the slot
`timescale 1ns/1ps

module dma_chan_sched import dma_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [NUM_REQ-1:0]  req,
    output chan_t               chan_num,
    input  addr_t               sel_src,
    input  addr_t               sel_dst,
    input  addr_t               sel_cnt,
    input  ctrl_t               sel_ctrl,
    input  mask_t               src_mask,
    input  mask_t               dst_mask,
    input  logic                sel_rpend,
    input  logic                sel_wpend,
    input  word_t               sel_rdata,
    input  logic                mst_busy,
    output logic                mst_cs,
    output logic                mst_wr,
    output chan_t               mst_seq,
    output mask_t               mst_mask,
    output addr_t               mst_addr,
    output word_t               mst_wdata,
    output logic [NUM_CHAN-1:0] update
);

    logic [NUM_REQ-1:0] req_d;
    chan_state_e        state_r [NUM_CHAN];
    chan_state_e        cur_state;
    chan_state_e        next_state;
    logic               src_req;
    logic               dst_req;

    assign cur_state = state_r[chan_num];
    assign src_req   = req_d[sel_ctrl[CTRL_SRC_REQ_LSB +: REQ_SEL_W]];
    assign dst_req   = req_d[sel_ctrl[CTRL_DST_REQ_LSB +: REQ_SEL_W]];

    always_comb
    begin
        next_state = cur_state;
        mst_cs     = 1'b0;
        mst_wr     = 1'b0;
        mst_seq    = '0;
        mst_mask   = '0;
        mst_addr   = '0;
        mst_wdata  = '0;
        update     = '0;

        if (sel_cnt == '0)
            next_state = ST_SRC_RDY;    // Idle channel
        else
        begin
            case (cur_state)
                ST_SRC_RDY:
                    if (src_req && !sel_rpend && !sel_wpend)
                        next_state = ST_RD_REQ;
                ST_RD_REQ:
                begin
                    mst_cs   = 1'b1;
                    mst_seq  = chan_num;
                    mst_mask = src_mask;
                    mst_addr = {sel_src[ADDR_W-1:2], 2'b00};
                    if (!mst_busy)
                        next_state = ST_RD_RSP;
                end
                ST_RD_RSP:
                    if (!sel_rpend)
                        next_state = ST_DST_RDY;
                ST_DST_RDY:
                    if (dst_req)
                        next_state = ST_WR_REQ;
                ST_WR_REQ:
                begin
                    mst_cs    = 1'b1;
                    mst_wr    = 1'b1;
                    mst_seq   = chan_num;
                    mst_mask  = dst_mask;
                    mst_addr  = {sel_dst[ADDR_W-1:2], 2'b00};
                    mst_wdata = sel_rdata;
                    if (!mst_busy)
                        next_state = ST_WR_RSP;
                end
                ST_WR_RSP:
                    if (!sel_wpend)
                        next_state = ST_STATUS;
                ST_STATUS:
                begin
                    update     = NUM_CHAN'(1) << chan_num;
                    next_state = ST_SRC_RDY;
                end
                default:
                    next_state = ST_SRC_RDY;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            chan_num <= '0;
            req_d    <= '0;
            for (int i = 0; i < NUM_CHAN; i++)
                state_r[i] <= ST_SRC_RDY;
        end
        else
        begin
            chan_num          <= chan_num + 1'b1;    // One slot per cycle
            req_d             <= req;
            state_r[chan_num] <= next_state;
        end
    end

    // A busy request comes back in the owner's next slot unchanged
    a_busy_retry: assert property (@(posedge clk) disable iff (rst)
        (mst_cs && mst_busy) |-> ##4 (mst_cs && mst_seq == $past(mst_seq, 4) &&
            mst_wr == $past(mst_wr, 4) && mst_addr == $past(mst_addr, 4) &&
            mst_mask == $past(mst_mask, 4)));

endmodule

// ==== hdl/dma_top.sv ====
// Top level of the four-channel DMA engine
// Register port, memory master port and request lines
`timescale 1ns/1ps

module dma_top import dma_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               reg_cs,
    input  logic               reg_wr,
    input  reg_off_t           reg_addr,
    input  word_t              reg_wdata,
    output word_t              reg_rdata,
    output logic               mst_cs,
    output chan_t              mst_seq,
    input  logic               mst_busy,
    output logic               mst_wr,
    output mask_t              mst_mask,
    output addr_t              mst_addr,
    output word_t              mst_wdata,
    input  logic               rdone,
    input  logic               wdone,
    input  chan_t              rsp_seq,
    input  mask_t              rsp_mask,
    input  word_t              rsp_data,
    input  logic [NUM_REQ-1:0] req
);

    chan_t               chan_num;
    logic [NUM_CHAN-1:0] update;
    addr_t               sel_src;
    addr_t               sel_dst;
    addr_t               sel_cnt;
    ctrl_t               sel_ctrl;
    addr_t               next_src;
    addr_t               next_dst;
    addr_t               next_cnt;
    mask_t               src_mask;
    mask_t               dst_mask;
    logic                sel_rpend;
    logic                sel_wpend;
    word_t               sel_rdata;

    dma_reg_file u_reg_file (
        .clk(clk), .rst(rst),
        .reg_cs(reg_cs), .reg_wr(reg_wr), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .chan_num(chan_num), .update(update),
        .next_src(next_src), .next_dst(next_dst), .next_cnt(next_cnt),
        .sel_src(sel_src), .sel_dst(sel_dst), .sel_cnt(sel_cnt), .sel_ctrl(sel_ctrl)
    );

    dma_step_calc u_step_calc (
        .sel_src(sel_src), .sel_dst(sel_dst), .sel_cnt(sel_cnt), .sel_ctrl(sel_ctrl),
        .next_src(next_src), .next_dst(next_dst), .next_cnt(next_cnt),
        .src_mask(src_mask), .dst_mask(dst_mask)
    );

    dma_resp_tracker u_resp_tracker (
        .clk(clk), .rst(rst),
        .mst_cs(mst_cs), .mst_wr(mst_wr), .mst_busy(mst_busy), .mst_seq(mst_seq),
        .rdone(rdone), .wdone(wdone), .rsp_seq(rsp_seq),
        .rsp_mask(rsp_mask), .rsp_data(rsp_data),
        .chan_num(chan_num),
        .sel_rpend(sel_rpend), .sel_wpend(sel_wpend), .sel_rdata(sel_rdata)
    );

    dma_chan_sched u_chan_sched (
        .clk(clk), .rst(rst), .req(req), .chan_num(chan_num),
        .sel_src(sel_src), .sel_dst(sel_dst), .sel_cnt(sel_cnt), .sel_ctrl(sel_ctrl),
        .src_mask(src_mask), .dst_mask(dst_mask),
        .sel_rpend(sel_rpend), .sel_wpend(sel_wpend), .sel_rdata(sel_rdata),
        .mst_busy(mst_busy), .mst_cs(mst_cs), .mst_wr(mst_wr), .mst_seq(mst_seq),
        .mst_mask(mst_mask), .mst_addr(mst_addr), .mst_wdata(mst_wdata),
        .update(update)
    );

endmodule

// ==== verif/dma_mem_model.sv ====
// Behavioral memory for the DMA testbench
// 16K words, byte-masked writes, full-word reads,
// random busy and random response delay per channel
`timescale 1ns/1ps

module dma_mem_model import dma_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  mst_cs,
    input  logic  mst_wr,
    input  chan_t mst_seq,
    input  mask_t mst_mask,
    input  addr_t mst_addr,
    input  word_t mst_wdata,
    output logic  mst_busy,
    output logic  rdone,
    output logic  wdone,
    output chan_t rsp_seq,
    output mask_t rsp_mask,
    output word_t rsp_data
);

    localparam int MEM_WORDS = 16384;
    localparam int MAX_DELAY = 6;

    word_t       mem       [MEM_WORDS];
    logic        pend_vld  [NUM_CHAN];
    logic        pend_wr   [NUM_CHAN];
    mask_t       pend_mask [NUM_CHAN];
    word_t       pend_data [NUM_CHAN];
    int unsigned pend_dly  [NUM_CHAN];
    logic [13:0] idx;

    assign idx = mst_addr[15:2];

    always @(posedge clk or posedge rst)
    begin : serve
        logic sent;
        sent = 1'b0;
        if (rst)
        begin
            mst_busy <= 1'b0;
            rdone    <= 1'b0;
            wdone    <= 1'b0;
            rsp_seq  <= '0;
            rsp_mask <= '0;
            rsp_data <= '0;
            for (int i = 0; i < NUM_CHAN; i++)
                pend_vld[i] <= 1'b0;
        end
        else
        begin
            rdone    <= 1'b0;
            wdone    <= 1'b0;
            mst_busy <= ($urandom % 4) == 0;
            // One response per cycle, lowest ready channel first
            for (int i = 0; i < NUM_CHAN; i++)
            begin
                if (pend_vld[i] && pend_dly[i] != 0)
                    pend_dly[i] <= pend_dly[i] - 1;
                else if (pend_vld[i] && !sent)
                begin
                    sent = 1'b1;
                    rdone       <= !pend_wr[i];
                    wdone       <= pend_wr[i];
                    rsp_seq     <= chan_t'(i);
                    rsp_mask    <= pend_mask[i];
                    rsp_data    <= pend_data[i];
                    pend_vld[i] <= 1'b0;
                end
            end
            if (mst_cs && !mst_busy)
            begin
                pend_vld[mst_seq]  <= 1'b1;
                pend_wr[mst_seq]   <= mst_wr;
                pend_mask[mst_seq] <= mst_mask;
                pend_dly[mst_seq]  <= $urandom % MAX_DELAY;
                pend_data[mst_seq] <= mst_wr ? '0 : mem[idx];    // Read data taken at accept
                for (int b = 0; b < 4; b++)
                    if (mst_wr && mst_mask[b])
                        mem[idx][8*b +: 8] <= mst_wdata[8*b +: 8];
            end
        end
    end

endmodule

// ==== verif/dma_tb.sv ====
// Testbench for the four-channel DMA engine
// Clock and reset, vector file reader, register port tasks,
// memory checks and a watchdog scaled by the transfer steps
`timescale 1ns/1ps

module dma_tb import dma_pkg::*;
();

    localparam int SEED            = 80;
    localparam int CYCLES_PER_STEP = 200;
    localparam int MARGIN_CYCLES   = 3000;

    logic               clk;
    logic               rst;
    logic               reg_cs;
    logic               reg_wr;
    reg_off_t           reg_addr;
    word_t              reg_wdata;
    word_t              reg_rdata;
    logic               mst_cs;
    chan_t              mst_seq;
    logic               mst_busy;
    logic               mst_wr;
    mask_t              mst_mask;
    addr_t              mst_addr;
    word_t              mst_wdata;
    logic               rdone;
    logic               wdone;
    chan_t              rsp_seq;
    mask_t              rsp_mask;
    word_t              rsp_data;
    logic [NUM_REQ-1:0] req;

    int    errors      = 0;
    int    checks      = 0;
    int    cycle_count = 0;
    int    cycle_limit = MARGIN_CYCLES;
    ctrl_t ctrl_shadow [NUM_CHAN];    // Last control word written per channel

    dma_top dut (
        .clk(clk), .rst(rst),
        .reg_cs(reg_cs), .reg_wr(reg_wr), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .mst_cs(mst_cs), .mst_seq(mst_seq), .mst_busy(mst_busy), .mst_wr(mst_wr),
        .mst_mask(mst_mask), .mst_addr(mst_addr), .mst_wdata(mst_wdata),
        .rdone(rdone), .wdone(wdone), .rsp_seq(rsp_seq),
        .rsp_mask(rsp_mask), .rsp_data(rsp_data), .req(req)
    );

    dma_mem_model u_mem (
        .clk(clk), .rst(rst),
        .mst_cs(mst_cs), .mst_wr(mst_wr), .mst_seq(mst_seq), .mst_mask(mst_mask),
        .mst_addr(mst_addr), .mst_wdata(mst_wdata), .mst_busy(mst_busy),
        .rdone(rdone), .wdone(wdone), .rsp_seq(rsp_seq),
        .rsp_mask(rsp_mask), .rsp_data(rsp_data)
    );

    always #5 clk = ~clk;

    function automatic int unsigned step_bytes(ctrl_t ctrl);
        case (ctrl[CTRL_SIZE_LSB +: 2])
            SIZE_8:  return 1;
            SIZE_16: return 2;
            default: return 4;
        endcase
    endfunction

    task automatic write_reg(input reg_off_t addr, input word_t data);
        @(posedge clk);
        reg_cs    <= 1'b1;
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_cs <= 1'b0;
        reg_wr <= 1'b0;
    endtask

    task automatic read_reg(input reg_off_t addr, output word_t data);
        @(posedge clk);
        reg_cs   <= 1'b1;
        reg_wr   <= 1'b0;
        reg_addr <= addr;
        @(negedge clk);
        data = reg_rdata;    // Read mux is combinational
        @(posedge clk);
        reg_cs <= 1'b0;
    endtask

    task automatic check_reg(input reg_off_t addr, input word_t expected);
        word_t got;
        read_reg(addr, got);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("** Error at %0t ns: reg_rdata[0x%02h] = 0x%08h, expected 0x%08h",
                     $time, addr, got, expected);
        end
    endtask

    task automatic check_mem(input addr_t addr, input word_t expected);
        word_t got;
        got = u_mem.mem[addr[15:2]];
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("** Error at %0t ns: mem[0x%04h] = 0x%08h, expected 0x%08h",
                     $time, addr, got, expected);
        end
    endtask

    // Poll the count register until the channel is idle
    task automatic wait_idle(input chan_t ch);
        word_t cnt;
        cnt = '1;
        while (cnt != '0)
            read_reg(reg_off_t'(16 * ch) + REG_CNT, cnt);
    endtask

    task automatic run_vectors();
        int                 fd;
        int                 code;
        logic [7:0]         op;
        word_t              a;
        word_t              b;
        logic [8*256-1:0]   skip_line;
        fd = $fopen("verif/dma_vectors.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Cannot open verif/dma_vectors.txt");
        end
        else
        begin
            while ($fscanf(fd, " %c", op) == 1)
            begin
                if (op == "#")
                    code = $fgets(skip_line, fd);
                else if (op == "Q" || op == "D")
                    code = $fscanf(fd, "%h", a) + 1;
                else
                    code = $fscanf(fd, "%h %h", a, b);
                if (op != "#" && code != 2)
                begin
                    errors++;
                    $display("Vector file has a bad operand list after op %c", op);
                end
                else
                begin
                    case (op)
                        "#": ;
                        "W":
                        begin
                            write_reg(a[5:0], b);
                            if (a[3:2] == 2'd2)
                                ctrl_shadow[a[5:4]] = b[CTRL_W-1:0];
                            else if (a[3:2] == 2'd3)
                                cycle_limit += CYCLES_PER_STEP *
                                    (b[ADDR_W-1:0] / step_bytes(ctrl_shadow[a[5:4]]));
                        end
                        "R": check_reg(a[5:0], b);
                        "M": u_mem.mem[a[15:2]] <= b;
                        "E": check_mem(a[ADDR_W-1:0], b);
                        "D": wait_idle(a[1:0]);
                        "Q":
                        begin
                            @(posedge clk);
                            req <= a[NUM_REQ-1:0];
                        end
                        default:
                        begin
                            errors++;
                            $display("Unknown vector operation %c", op);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    initial
    begin
        void'($urandom(SEED));
        clk       = 1'b0;
        rst       = 1'b1;
        reg_cs    = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        req       = '0;
        for (int i = 0; i < NUM_CHAN; i++)
            ctrl_shadow[i] = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        run_vectors();
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // Limit grows by a fixed budget for every transfer step started
    initial
    begin
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, a transfer never finished (checks: %0d, errors: %0d)",
                 cycle_count, checks, errors);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== verif/dma_vectors.txt ====
# Ops (hex operands): W reg data | R reg expect | M byte_addr data | E byte_addr expect
# Q req_levels | D chan (wait for count zero); reg = 16*chan + 0 src, 4 dst, 8 ctrl, C count
R 3C 00000000  R 30 00000000  W 30 FFFFFFFF  R 30 003FFFFF
W 34 12345678  R 34 00345678  W 38 ABCDE123  R 38 00000123
W 3C FFC00010  R 3C 00000010  W 3C 00000000  R 3C 00000000
Q FEFF
# 32-bit copy, both increments
M 1000 11111111  M 1004 22222222  M 1008 33333333  M 100C 44444444  M 2010 CAFEF00D
W 00 00001000  W 04 00002000  W 08 00000B10  W 0C 00000010  D 0
E 2000 11111111  E 2004 22222222  E 2008 33333333  E 200C 44444444  E 2010 CAFEF00D
R 00 00001010  R 04 00002010  R 0C 00000000
# 8-bit copy, lane 1 to lane 2
M 3000 03020100  M 3004 07060504  M 3100 EEEEEEEE  M 3104 EEEEEEEE
W 10 00003001  W 14 00003102  W 18 00000332  W 1C 00000005  D 1
E 3100 0201EEEE  E 3104 EE050403  R 10 00003006  R 14 00003107  R 1C 00000000
# 16-bit copy, upper half to lower half
M 4000 44443333  M 4004 66665555  M 4100 EEEEEEEE  M 4104 EEEEEEEE
W 20 00004002  W 24 00004100  W 28 00000754  W 2C 00000006  D 2
E 4100 55554444  E 4104 EEEE6666  R 20 00004008  R 24 00004106
# Fixed source word
M 5000 5A5A1234  M 5004 99999999  M 510C 0BADC0DE
W 30 00005000  W 34 00005100  W 38 00000A76  W 3C 0000000C  D 3
E 5100 5A5A1234  E 5104 5A5A1234  E 5108 5A5A1234  E 510C 0BADC0DE
R 30 00005000  R 34 0000510C  R 3C 00000000
# Channel 0 held on request line 8 while channel 1 copies
M 6000 01234567  M 6004 89ABCDEF  M 6100 00000000  M 6104 00000000
W 00 00006000  W 04 00006100  W 08 00000B18  W 0C 00000008
W 10 00001000  W 14 00006200  W 18 00000B32  W 1C 00000010  D 1
E 6200 11111111  E 6204 22222222  E 6208 33333333  E 620C 44444444
R 0C 00000008  R 04 00006100  E 6100 00000000  E 6104 00000000
Q FFFF  D 0  E 6100 01234567  E 6104 89ABCDEF  R 04 00006108
# All four channels at once
M 7000 A0000001  M 7004 A0000002  M 7008 A0000003  M 700C A0000004
M 7200 B3B2B1B0  M 7204 B7B6B5B4  M 7300 00000000  M 7304 FFFFFFFF
M 7400 C1C1C0C0  M 7500 11111111  M 7504 22222222  M 7600 D00DD00D
W 00 00007000  W 04 00007100  W 08 00000B10  W 10 00007203  W 14 00007300  W 18 00000332
W 20 00007400  W 24 00007502  W 28 00000754  W 30 00007600  W 34 00007700  W 38 00000A76
W 0C 00000010  W 1C 00000004  W 2C 00000004  W 3C 00000008  D 0  D 1  D 2  D 3
E 7100 A0000001  E 7104 A0000002  E 7108 A0000003  E 710C A0000004
E 7300 B6B5B4B3  E 7304 FFFFFFFF  E 7500 C0C01111  E 7504 2222C1C1
E 7700 D00DD00D  E 7704 D00DD00D  R 34 00007708

// ==== dma_top.f ====
hdl/dma_pkg.sv
hdl/dma_reg_file.sv
hdl/dma_step_calc.sv
hdl/dma_resp_tracker.sv
hdl/dma_chan_sched.sv
hdl/dma_top.sv
verif/dma_mem_model.sv
verif/dma_tb.sv

// ==== Bender.yml ====
package:
  name: dma_top

sources:
  - files:
      - hdl/dma_pkg.sv
      - hdl/dma_reg_file.sv
      - hdl/dma_step_calc.sv
      - hdl/dma_resp_tracker.sv
      - hdl/dma_chan_sched.sv
      - hdl/dma_top.sv
  - target: test
    files:
      - verif/dma_mem_model.sv
      - verif/dma_tb.sv
